//--- Bender.yml
package:
  name: xmodem_rx

dependencies: {}

sources:
  - hw/xmodem_pkg.sv
  - hw/uart_rx.sv
  - hw/xmodem_frame_check.sv
  - hw/block_store.sv
  - hw/uart_tx.sv
  - hw/xmodem_rx.sv
  - target: test
    files:
      - dv/xmodem_rx_tb.sv

//--- dv/xmodem_rx_tb.sv
module xmodem_rx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import xmodem_pkg::*;

    localparam int CYC_PER_BIT    = 8;
    localparam int REPLY_TIMEOUT  = 40 * CYC_PER_BIT; // cycles until a start bit
    localparam int STREAM_TIMEOUT = 400;

    logic       clk;
    logic       reset;
    logic       rx_line;
    logic       tx_line;
    logic [7:0] out_data;
    logic       out_valid;
    logic       out_last;
    logic [7:0] out_block;
    logic       done;

    integer     seed = 32'h1fed_3130;
    int         errors;
    int         test_errs;
    int         tests_run;
    int         tests_failed;
    int         done_cnt;
    logic [7:0] model_expected; // next block number the checker should take
    logic [7:0] blk_data [BLOCK_BYTES];
    logic [7:0] q_data [$];
    logic       q_last [$];
    logic [7:0] q_block [$];

    xmodem_rx #(
        .CYC_PER_BIT(CYC_PER_BIT)
    ) dut_i (
        .clk      (clk),
        .reset    (reset),
        .rx_line  (rx_line),
        .tx_line  (tx_line),
        .out_data (out_data),
        .out_valid(out_valid),
        .out_last (out_last),
        .out_block(out_block),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (out_valid) begin
                q_data.push_back(out_data);
                q_last.push_back(out_last);
                q_block.push_back(out_block);
            end
            if (done) begin
                done_cnt++;
            end
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] got_v,
                                   input logic [31:0] exp_v);
        $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, sig, got_v, exp_v);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        errors++;
    endtask

    // start, 8 data bits lsb first, stop
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_line <= frame[i];
            repeat (CYC_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic get_reply(output logic [7:0] b, output logic got);
        int wait_cnt;
        got      = 1'b0;
        b        = '0;
        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
        end while (tx_line && wait_cnt < REPLY_TIMEOUT);
        if (tx_line) begin
            return; // nothing on the line
        end
        repeat (CYC_PER_BIT / 2) @(negedge clk); // middle of start bit
        if (tx_line) begin
            return;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CYC_PER_BIT) @(negedge clk);
            b[i] = tx_line;
        end
        repeat (CYC_PER_BIT) @(negedge clk);
        got = tx_line; // stop bit has to read high
    endtask

    task automatic check_reply(input logic got, input logic [7:0] reply,
                               input logic [7:0] want);
        assert (got) else report_failure("no reply byte seen on tx_line");
        if (got) begin
            assert (reply == want) else report_mismatch("tx_line reply", reply, want);
        end
    endtask

    function automatic logic [7:0] block_sum();
        logic [7:0] s;
        s = '0;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            s = s + blk_data[i];
        end
        return s;
    endfunction

    task automatic fill_random();
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            blk_data[i] = 8'($random(seed));
        end
    endtask

    task automatic run_block(input logic [7:0] num, input logic [7:0] compl,
                             input logic [7:0] cks);
        logic [7:0] reply;
        logic [7:0] want_reply;
        logic       got;
        logic       good;
        logic       want_accept;
        int         wait_cnt;
        // verdict as XMODEM defines it
        good        = (compl == ~num) && (cks == block_sum());
        want_accept = 1'b0;
        if (good && num == model_expected) begin
            want_reply     = ACK_BYTE;
            want_accept    = 1'b1;
            model_expected = model_expected + 8'd1;
        end else if (good && num == model_expected - 8'd1) begin
            want_reply = ACK_BYTE; // repeat of a block already taken
        end else begin
            want_reply = NAK_BYTE;
        end
        q_data.delete();
        q_last.delete();
        q_block.delete();
        send_byte(SOH_BYTE);
        send_byte(num);
        send_byte(compl);
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            send_byte(blk_data[i]);
        end
        fork
            send_byte(cks);
            get_reply(reply, got);
        join
        check_reply(got, reply, want_reply);
        // stream started before the reply and outlasts it
        wait_cnt = 0;
        while ((out_valid || (want_accept && q_data.size() < BLOCK_BYTES))
               && wait_cnt < STREAM_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (wait_cnt >= STREAM_TIMEOUT) begin
            report_failure("timed out waiting for the output stream to finish");
        end
        if (want_accept) begin
            assert (q_data.size() == BLOCK_BYTES)
                else report_mismatch("out_valid cycles", q_data.size(), BLOCK_BYTES);
            for (int i = 0; i < q_data.size() && i < BLOCK_BYTES; i++) begin
                assert (q_data[i] == blk_data[i])
                    else report_mismatch("out_data", q_data[i], blk_data[i]);
                assert (q_last[i] == (i == BLOCK_BYTES - 1))
                    else report_mismatch("out_last", q_last[i], i == BLOCK_BYTES - 1);
                assert (q_block[i] == num) else report_mismatch("out_block", q_block[i], num);
            end
        end else begin
            assert (q_data.size() == 0)
                else report_failure("a rejected or repeated block reached the output");
        end
    endtask

    task automatic start_test();
        test_errs = errors;
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (errors == test_errs) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - test_errs);
        end
    endtask

    initial begin
        logic [7:0] sum;
        logic [7:0] b;
        logic [7:0] reply;
        logic       got;
        rx_line        = 1'b1;
        reset          = 1'b1;
        model_expected = 8'd1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        start_test();
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            assert (tx_line === 1'b1) else report_mismatch("tx_line", tx_line, 1);
            assert (out_valid === 1'b0) else report_mismatch("out_valid", out_valid, 0);
            assert (done === 1'b0) else report_mismatch("done", done, 0);
        end
        end_test(1, "idle after reset");

        start_test();
        for (int n = 1; n <= 3; n++) begin
            fill_random();
            run_block(8'(n), ~8'(n), block_sum());
        end
        end_test(2, "good blocks in sequence");

        start_test();
        fill_random();
        sum = block_sum();
        run_block(model_expected, ~model_expected, sum + 8'd1); // checksum off by one
        run_block(model_expected, ~model_expected, sum);
        end_test(3, "bad checksum then resend");

        start_test();
        fill_random();
        sum = block_sum();
        run_block(model_expected, ~model_expected ^ 8'h5a, sum);
        run_block(model_expected + 8'd1, ~(model_expected + 8'd1), sum); // skips ahead
        run_block(model_expected, ~model_expected, sum); // still the same number wanted
        end_test(4, "bad complement and skipped number");

        start_test();
        run_block(model_expected - 8'd1, ~(model_expected - 8'd1), sum);
        fill_random();
        run_block(model_expected, ~model_expected, block_sum());
        end_test(5, "repeated block");

        start_test();
        for (int i = 0; i < 3; i++) begin
            b = 8'($random(seed));
            if (b == SOH_BYTE || b == EOT_BYTE) begin
                b = 8'h55;
            end
            fork
                send_byte(b);
                get_reply(reply, got);
            join
            assert (!got) else report_failure("reply sent for a stray byte while idle");
        end
        fork
            send_byte(EOT_BYTE);
            get_reply(reply, got);
        join
        check_reply(got, reply, ACK_BYTE);
        assert (done_cnt == 1) else report_mismatch("done pulse count", done_cnt, 1);
        end_test(6, "stray bytes and end of transfer");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- hw/block_store.sv
module block_store (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rx_data,
    input  logic       data_we,
    input  logic [6:0] data_index,
    input  logic [7:0] block_num,
    input  logic       accept,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last,
    output logic [7:0] out_block
);

    import xmodem_pkg::*;

    logic [7:0] mem [BLOCK_BYTES];
    logic [6:0] rd_cnt;
    logic       streaming;

    // a rejected block is left here and overwritten by the next one
    always_ff @(posedge clk) begin
        if (data_we) begin
            mem[data_index] <= rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_block <= block_num; // held for the whole stream
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            streaming <= 1'b0;
            rd_cnt    <= '0;
        end else if (accept) begin
            streaming <= 1'b1;
            rd_cnt    <= '0;
        end else if (streaming) begin
            rd_cnt <= rd_cnt + 7'd1;
            if (rd_cnt == 7'(BLOCK_BYTES - 1)) begin
                streaming <= 1'b0;
            end
        end
    end

    assign out_valid = streaming;
    assign out_data  = mem[rd_cnt];
    assign out_last  = streaming && (rd_cnt == 7'(BLOCK_BYTES - 1));

    // the next block takes at least a reply time to arrive, far longer than the stream
    a_no_overlap: assert property (
        @(posedge clk) disable iff (reset) accept |-> !streaming
    ) else $error("block accepted while previous block still streaming");

endmodule

//--- hw/uart_rx.sv
module uart_rx #(
    parameter int CYC_PER_BIT = xmodem_pkg::DEFAULT_CYC_PER_BIT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_line,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    localparam int CNT_W = $clog2(CYC_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CYC_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CYC_PER_BIT - 1);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_bits,
        rx_stop
    } rx_state_t;

    rx_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift;
    logic             line_s1;
    logic             line_s2;
    logic             line_prev;
    logic             tick;

    // start bit is checked at its middle, every later bit one full period on
    assign tick = (state == rx_start) ? (cnt == HALF_BIT) : (cnt == FULL_BIT);
    assign rx_data = shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            line_s1   <= 1'b1; // line idles high
            line_s2   <= 1'b1;
            line_prev <= 1'b1;
            state     <= rx_idle;
            cnt       <= '0;
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
        end else begin
            line_s1   <= rx_line;
            line_s2   <= line_s1;
            line_prev <= line_s2;
            rx_valid  <= 1'b0;

            if (state == rx_idle || tick) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end

            case (state)
                rx_idle: begin
                    if (line_prev && !line_s2) begin // falling edge of start bit
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    if (tick) begin
                        bit_cnt <= '0;
                        // a glitch shorter than half a bit goes back to idle
                        state   <= line_s2 ? rx_idle : rx_bits;
                    end
                end
                rx_bits: begin
                    if (tick) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= rx_stop;
                        end
                    end
                end
                default: begin
                    if (tick) begin
                        rx_valid <= line_s2; // framing error drops the byte
                        state    <= rx_idle;
                    end
                end
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == rx_bits && tick) begin
            shift <= {line_s2, shift[7:1]};
        end
    end

endmodule

//--- hw/uart_tx.sv
module uart_tx #(
    parameter int CYC_PER_BIT = xmodem_pkg::DEFAULT_CYC_PER_BIT
) (
    input  logic clk,
    input  logic reset,
    input  logic send_ack,
    input  logic send_nak,
    output logic tx_line
);

    import xmodem_pkg::*;

    localparam int TMR_W = $clog2(CYC_PER_BIT);
    localparam logic [TMR_W-1:0] LAST_TICK = TMR_W'(CYC_PER_BIT - 1);

    logic [9:0]       frame; // stop, data lsb first, start
    logic [TMR_W-1:0] tmr;
    logic [3:0]       bit_cnt;
    logic             busy;
    logic [7:0]       reply;

    assign reply   = send_nak ? NAK_BYTE : ACK_BYTE;
    assign tx_line = frame[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            frame   <= '1; // idle high
            tmr     <= '0;
            bit_cnt <= '0;
            busy    <= 1'b0;
        end else if (send_ack || send_nak) begin
            frame   <= {1'b1, reply, 1'b0};
            tmr     <= '0;
            bit_cnt <= '0;
            busy    <= 1'b1;
        end else if (busy) begin
            if (tmr == LAST_TICK) begin
                tmr     <= '0;
                frame   <= {1'b1, frame[9:1]}; // ones fill in behind
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0; // stop bit done
                end
            end else begin
                tmr <= tmr + 1'b1;
            end
        end
    end

    // the sender waits for our reply, so a new verdict never lands mid-byte
    a_not_busy: assert property (
        @(posedge clk) disable iff (reset) (send_ack || send_nak) |-> !busy
    ) else $error("reply requested while transmitter busy");

endmodule

//--- hw/xmodem_frame_check.sv
module xmodem_frame_check (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic       data_we,
    output logic [6:0] data_index,
    output logic [7:0] block_num,
    output logic       accept,
    output logic       send_ack,
    output logic       send_nak,
    output logic       done
);

    import xmodem_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_number,
        st_complement,
        st_data,
        st_checksum
    } fc_state_t;

    fc_state_t  state;
    logic [7:0] expected; // next block number we want
    logic [7:0] sum;
    logic [6:0] data_cnt;
    logic       compl_ok;
    logic       sum_ok;
    logic       in_sequence;
    logic       is_repeat;

    assign data_we    = rx_valid && (state == st_data);
    assign data_index = data_cnt;

    // only meaningful while the checksum byte is on rx_data
    assign sum_ok      = compl_ok && (rx_data == sum);
    assign in_sequence = (block_num == expected);
    assign is_repeat   = (block_num == expected - 8'd1); // our ack was lost

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            expected <= 8'd1;
            accept   <= 1'b0;
            send_ack <= 1'b0;
            send_nak <= 1'b0;
            done     <= 1'b0;
        end else begin
            accept   <= 1'b0;
            send_ack <= 1'b0;
            send_nak <= 1'b0;
            done     <= 1'b0;

            if (rx_valid) begin
                case (state)
                    st_idle: begin
                        if (rx_data == SOH_BYTE) begin
                            state <= st_number;
                        end else if (rx_data == EOT_BYTE) begin
                            send_ack <= 1'b1;
                            done     <= 1'b1;
                        end
                        // anything else is line noise between blocks
                    end
                    st_number: begin
                        state <= st_complement;
                    end
                    st_complement: begin
                        state <= st_data;
                    end
                    st_data: begin
                        if (data_cnt == 7'(BLOCK_BYTES - 1)) begin
                            state <= st_checksum;
                        end
                    end
                    default: begin
                        state <= st_idle;
                        if (sum_ok && in_sequence) begin
                            accept   <= 1'b1;
                            send_ack <= 1'b1;
                            expected <= expected + 8'd1; // wraps 255 -> 0
                        end else if (sum_ok && is_repeat) begin
                            send_ack <= 1'b1; // already stored, just resync sender
                        end else begin
                            send_nak <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // per-block payload, cleared at each SOH
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                st_idle: begin
                    sum      <= '0;
                    data_cnt <= '0;
                end
                st_number: begin
                    block_num <= rx_data;
                end
                st_complement: begin
                    compl_ok <= (rx_data == ~block_num);
                end
                st_data: begin
                    sum      <= sum + rx_data; // 8-bit additive checksum
                    data_cnt <= data_cnt + 7'd1;
                end
                default: begin
                end
            endcase
        end
    end

    // the reply transmitter would send a garbled byte otherwise
    a_one_verdict: assert property (
        @(posedge clk) disable iff (reset) !(send_ack && send_nak)
    ) else $error("ack and nak requested in the same cycle");

endmodule

//--- hw/xmodem_pkg.sv
package xmodem_pkg;

    // XMODEM control bytes, checksum variant
    localparam logic [7:0] SOH_BYTE = 8'h01; // start of a 128-byte block
    localparam logic [7:0] EOT_BYTE = 8'h04; // sender has nothing more
    localparam logic [7:0] ACK_BYTE = 8'h06;
    localparam logic [7:0] NAK_BYTE = 8'h15; // asks the sender to repeat

    // data bytes between the complement byte and the checksum
    localparam int BLOCK_BYTES = 128;

    // serial bit period in clock cycles
    // the receiver samples at half of this, so keep it at 4 or more
    localparam int DEFAULT_CYC_PER_BIT = 16;

endpackage

//--- hw/xmodem_rx.sv
module xmodem_rx #(
    parameter int CYC_PER_BIT = xmodem_pkg::DEFAULT_CYC_PER_BIT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_line,
    output logic       tx_line,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last,
    output logic [7:0] out_block,
    output logic       done
);

    logic [7:0] rx_data;
    logic       rx_valid;
    logic       data_we;
    logic [6:0] data_index;
    logic [7:0] block_num;
    logic       accept;
    logic       send_ack;
    logic       send_nak;

    uart_rx #(
        .CYC_PER_BIT(CYC_PER_BIT)
    ) uart_rx_i (
        .clk     (clk),
        .reset   (reset),
        .rx_line (rx_line),
        .rx_data (rx_data),
        .rx_valid(rx_valid)
    );

    xmodem_frame_check frame_check_i (
        .clk       (clk),
        .reset     (reset),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .data_we   (data_we),
        .data_index(data_index),
        .block_num (block_num),
        .accept    (accept),
        .send_ack  (send_ack),
        .send_nak  (send_nak),
        .done      (done)
    );

    // fills straight from the receiver, the checker only says where
    block_store block_store_i (
        .clk       (clk),
        .reset     (reset),
        .rx_data   (rx_data),
        .data_we   (data_we),
        .data_index(data_index),
        .block_num (block_num),
        .accept    (accept),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_block (out_block)
    );

    uart_tx #(
        .CYC_PER_BIT(CYC_PER_BIT)
    ) uart_tx_i (
        .clk     (clk),
        .reset   (reset),
        .send_ack(send_ack),
        .send_nak(send_nak),
        .tx_line (tx_line)
    );

endmodule

//--- xmodem_rx.f
hw/xmodem_pkg.sv
hw/uart_rx.sv
hw/xmodem_frame_check.sv
hw/block_store.sv
hw/uart_tx.sv
hw/xmodem_rx.sv
dv/xmodem_rx_tb.sv
